// ==== common/flow_xbar_cfg.svh ====
// These sizes fix every type in the crossbar and NUM_POP must be a power of two no less than 2
`ifndef FLOW_XBAR_CFG_SVH
`define FLOW_XBAR_CFG_SVH

// --------------------
// Port counts
// --------------------
`define FLOW_XBAR_NUM_PUSH 4
`define FLOW_XBAR_NUM_POP 4

// --------------------
// Widths
// --------------------
`define FLOW_XBAR_DATA_W 16

// Destination id selects one pop port
`define FLOW_XBAR_DEST_W $clog2(`FLOW_XBAR_NUM_POP)

`endif

// ==== common/flow_xbar_pkg.sv ====
// Type widths follow the cfg macros only, so resizing means editing the cfg header
`default_nettype none

`include "flow_xbar_cfg.svh"

package flow_xbar_pkg;

  // --------------------
  // Vector types
  // --------------------

  // Item payload as carried end to end
  typedef logic [`FLOW_XBAR_DATA_W-1:0] payload_t;

  // Index of a pop port
  typedef logic [`FLOW_XBAR_DEST_W-1:0] dest_id_t;

  // One bit per source
  // Used for request, can_grant and grant rows
  typedef logic [`FLOW_XBAR_NUM_PUSH-1:0] push_mask_t;

  // --------------------
  // Flit
  // --------------------

  // What a source presents on its push port
  typedef struct packed {
    dest_id_t dest;
    payload_t data;
  } push_flit_t;

endpackage

`default_nettype wire

// ==== flow_xbar.f ====
+incdir+common
common/flow_xbar_pkg.sv
logic/flow_reg_fwd.sv
logic/rr_arbiter.sv
xbar/flow_demux.sv
xbar/flow_mux_core.sv
xbar/flow_xbar_core.sv
xbar/flow_xbar_top.sv
testbench/flow_xbar_assertions.sv
testbench/flow_xbar_tb.sv

// ==== logic/flow_reg_fwd.sv ====
// Single-entry forward slice with one cycle of latency and full throughput when pop_ready stays high
`default_nettype none

module flow_reg_fwd (
  input  logic                   clk,
  input  logic                   rst,

  input  logic                   push_valid,
  output logic                   push_ready,
  input  flow_xbar_pkg::payload_t push_data,

  output logic                   pop_valid,
  input  logic                   pop_ready,
  output flow_xbar_pkg::payload_t pop_data
);

  import flow_xbar_pkg::*;

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when the held item leaves this cycle
  assign push_ready = !valid_q || pop_ready;

  // --------------------
  // Valid flag
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (push_ready) begin
      valid_q <= push_valid;
    end
  end

  // --------------------
  // Payload
  // --------------------
  always_ff @(posedge clk) begin
    if (push_valid && push_ready) begin
      data_q <= push_data;
    end
  end

  assign pop_valid = valid_q;
  assign pop_data  = data_q;

endmodule

`default_nettype wire

// ==== logic/rr_arbiter.sv ====
// Needs at least two requesters and the grant is combinational from request and the pointer
`default_nettype none

module rr_arbiter (
  input  logic                     clk,
  input  logic                     rst,

  input  flow_xbar_pkg::push_mask_t request,
  input  logic                     enable_priority_update,

  output flow_xbar_pkg::push_mask_t can_grant,
  output flow_xbar_pkg::push_mask_t grant
);

  import flow_xbar_pkg::*;

  localparam int N = $bits(push_mask_t);

  // One-hot, marks the requester with top priority
  push_mask_t priority_ptr;
  push_mask_t at_or_above;
  push_mask_t masked_req;

  // --------------------
  // Winner selection
  // --------------------

  // Every bit position from the pointer upward
  assign at_or_above = ~(priority_ptr - push_mask_t'(1));
  assign masked_req  = request & at_or_above;

  // Lowest set bit of the masked row, else wrap to the lowest request overall
  always_comb begin
    if (|masked_req) begin
      can_grant = masked_req & (~masked_req + push_mask_t'(1));
    end else begin
      can_grant = request & (~request + push_mask_t'(1));
    end
  end

  // Only a grant that is consumed counts
  assign grant = can_grant & {N{enable_priority_update}};

  // --------------------
  // Priority pointer
  // --------------------

  // Move to the source just above the winner
  always_ff @(posedge clk) begin
    if (rst) begin
      priority_ptr <= push_mask_t'(1);
    end else if (|grant) begin
      priority_ptr <= {grant[N-2:0], grant[N-1]};
    end
  end

endmodule

`default_nettype wire

// ==== testbench/flow_xbar_assertions.sv ====
// Bound into flow_xbar_top as flow_xbar_checks and fail_count counts every failed check
`default_nettype none

`include "flow_xbar_cfg.svh"

module flow_xbar_assertions (
  input logic                                                clk,
  input logic                                                rst,
  input logic [`FLOW_XBAR_NUM_PUSH-1:0]                      push_valid,
  input logic [`FLOW_XBAR_NUM_PUSH-1:0]                      push_ready,
  input flow_xbar_pkg::push_flit_t [`FLOW_XBAR_NUM_PUSH-1:0] push_flit,
  input logic [`FLOW_XBAR_NUM_POP-1:0]                       pop_valid,
  input logic [`FLOW_XBAR_NUM_POP-1:0]                       pop_ready,
  input flow_xbar_pkg::payload_t [`FLOW_XBAR_NUM_POP-1:0]    pop_data,
  input flow_xbar_pkg::push_mask_t [`FLOW_XBAR_NUM_POP-1:0]  request,
  input flow_xbar_pkg::push_mask_t [`FLOW_XBAR_NUM_POP-1:0]  can_grant
);

  int fail_count = 0;

  // --------------------
  // Push side
  // --------------------
  for (genvar i = 0; i < `FLOW_XBAR_NUM_PUSH; i++) begin : gen_push
    push_hold: assert property (@(posedge clk) disable iff (rst)
      push_valid[i] && !push_ready[i] |=> push_valid[i] && $stable(push_flit[i]))
      else begin
        $error("push %0d dropped valid or changed its flit while stalled", i);
        fail_count++;
      end
  end

  // --------------------
  // Pop side
  // --------------------
  for (genvar j = 0; j < `FLOW_XBAR_NUM_POP; j++) begin : gen_pop
    pop_hold: assert property (@(posedge clk) disable iff (rst)
      pop_valid[j] && !pop_ready[j] |=> pop_valid[j] && $stable(pop_data[j]))
      else begin
        $error("pop %0d dropped valid or changed its data while stalled", j);
        fail_count++;
      end

    // Winner is a single requester
    grant_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(can_grant[j]) && ((can_grant[j] & ~request[j]) == '0))
      else begin
        $error("can_grant of pop %0d is not one-hot within request", j);
        fail_count++;
      end
  end

  reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> pop_valid == '0)
    else begin
      $error("pop_valid high while in reset");
      fail_count++;
    end

endmodule

bind flow_xbar_top flow_xbar_assertions flow_xbar_checks (.*);

`default_nettype wire

// ==== testbench/flow_xbar_tb.sv ====
// Assumes the 4x4 default sizes since payloads pack source and dest into 4-bit fields and seq into 8
`default_nettype none

`include "flow_xbar_cfg.svh"

module flow_xbar_tb;

  import flow_xbar_pkg::*;

  localparam int NP = `FLOW_XBAR_NUM_PUSH;
  localparam int NQ = `FLOW_XBAR_NUM_POP;
  localparam int NUM_TESTS = 6;
  // One lane slice plus one pop slice per source-destination pair
  localparam int PAIR_DEPTH = 2;

  typedef enum {READY_ALWAYS, READY_HOLD, READY_RANDOM} ready_mode_e;

  typedef struct {
    string       name;
    int          count [NP];
    bit          rand_dest;
    int          dest [NP];
    ready_mode_e ready_mode;
    int          ready_arg;
    bit          check_latency;
    bit          check_rr;
    bit          load_before_reset;
  } test_row_t;

  // --------------------
  // Stimulus table
  // --------------------
  // ready_arg is hold cycles for READY_HOLD and duty percent for READY_RANDOM
  // load_before_reset parks untracked items in the slices just before the row's reset
  test_row_t tests [NUM_TESTS] = '{
    '{"single_item", '{1, 0, 0, 0}, 1'b0, '{2, 0, 0, 0}, READY_ALWAYS, 0, 1'b1, 1'b0, 1'b0},
    '{"distinct_streams", '{8, 8, 8, 8}, 1'b0, '{1, 2, 3, 0}, READY_ALWAYS, 0, 1'b1, 1'b0, 1'b0},
    '{"shared_dest_rr", '{4, 4, 4, 4}, 1'b0, '{1, 1, 1, 1}, READY_ALWAYS, 0, 1'b0, 1'b1, 1'b0},
    '{"backpressure_hold", '{6, 6, 6, 6}, 1'b0, '{3, 2, 1, 0}, READY_HOLD, 20, 1'b0, 1'b0, 1'b0},
    '{"random_traffic", '{20, 20, 20, 20}, 1'b1, '{0, 0, 0, 0}, READY_RANDOM, 60, 1'b0, 1'b0, 1'b0},
    '{"reset_quiet", '{0, 0, 0, 0}, 1'b0, '{0, 0, 0, 0}, READY_ALWAYS, 0, 1'b0, 1'b0, 1'b1}
  };

  logic                clk;
  logic                rst;
  logic [NP-1:0]       push_valid;
  logic [NP-1:0]       push_ready;
  push_flit_t [NP-1:0] push_flit;
  logic [NQ-1:0]       pop_valid;
  logic [NQ-1:0]       pop_ready;
  payload_t [NQ-1:0]   pop_data;

  // One scoreboard queue per source-destination pair
  payload_t exp_q [NP][NQ][$];
  int       cyc_q [NP][NQ][$];
  int       rr_next [NQ];
  int       accepted [NP];
  int       cycle = 0;
  int       cur_row = 0;
  int       delivered = 0;

  flow_xbar_top UUT (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_flit  (push_flit),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // --------------------
  // Helpers
  // --------------------
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic int row_total();
    int sum;
    sum = 0;
    for (int s = 0; s < NP; s++) sum += tests[cur_row].count[s];
    return sum;
  endfunction

  function automatic int total_items();
    int sum;
    sum = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int s = 0; s < NP; s++) sum += tests[t].count[s];
    end
    return sum;
  endfunction

  // Fills every lane slice and pop slice on the diagonal with items the scoreboard never sees
  task automatic park_items();
    push_flit_t flit;
    @(posedge clk);
    #2;
    pop_ready = '0;
    for (int s = 0; s < NP; s++) begin
      flit.dest = dest_id_t'(s);
      flit.data = {4'(s), 4'(s), 8'hff};
      push_flit[s] = flit;
    end
    push_valid = '1;
    repeat (2) @(posedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    push_valid = '0;
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    pop_ready = '1;
    repeat (2) begin
      @(negedge clk);
      assert (pop_valid == '0) else fail_run("pop_valid went high right after reset");
    end
  endtask

  // Pushes one source's items in order
  task automatic drive_source(input int s);
    push_flit_t flit;
    int         last;
    last = 0;
    for (int n = 0; n < tests[cur_row].count[s]; n++) begin
      flit.dest = tests[cur_row].rand_dest ? dest_id_t'($urandom_range(NQ - 1))
                                            : dest_id_t'(tests[cur_row].dest[s]);
      flit.data = {4'(s), 4'(flit.dest), 8'(n)};
      push_valid[s] = 1'b1;
      push_flit[s] = flit;
      do begin
        @(negedge clk);
      end while (!push_ready[s]);
      exp_q[s][flit.dest].push_back(flit.data);
      cyc_q[s][flit.dest].push_back(cycle);
      if (tests[cur_row].check_latency && n > 0) begin
        assert (cycle == last + 1)
          else fail_run($sformatf("source %0d was not accepted back to back", s));
      end
      last = cycle;
      accepted[s]++;
      @(posedge clk);
      #2;
    end
    push_valid[s] = 1'b0;
  endtask

  task automatic drive_ready();
    int exp_acc;
    case (tests[cur_row].ready_mode)
      READY_HOLD: begin
        pop_ready = '0;
        repeat (tests[cur_row].ready_arg) @(negedge clk);
        for (int s = 0; s < NP; s++) begin
          exp_acc = (tests[cur_row].count[s] < PAIR_DEPTH) ? tests[cur_row].count[s] : PAIR_DEPTH;
          assert (accepted[s] == exp_acc)
            else fail_run($sformatf("mismatch %s accepted[%0d]: expected %0d actual %0d",
                                    tests[cur_row].name, s, exp_acc, accepted[s]));
          if (tests[cur_row].count[s] > PAIR_DEPTH) begin
            assert (!push_ready[s])
              else fail_run($sformatf("push_ready of source %0d stayed high with lanes full", s));
          end
        end
        @(posedge clk);
        #2;
        pop_ready = '1;
      end
      READY_RANDOM: begin
        while (delivered < row_total()) begin
          for (int j = 0; j < NQ; j++) begin
            pop_ready[j] = ($urandom_range(99) < tests[cur_row].ready_arg);
          end
          @(posedge clk);
          #2;
        end
        pop_ready = '1;
      end
      default: pop_ready = '1;
    endcase
  endtask

  // --------------------
  // Pop checker
  // --------------------
  task automatic check_pop(input int j);
    int       src;
    int       dst;
    int       lat;
    payload_t expected;
    string    name;
    name = tests[cur_row].name;
    src = int'(pop_data[j][15:12]);
    dst = int'(pop_data[j][11:8]);
    assert (dst == j)
      else fail_run($sformatf("mismatch %s port: expected %0d actual %0d", name, j, dst));
    assert (src < NP && exp_q[src][j].size() > 0)
      else fail_run($sformatf("port %0d popped %h with no pushed item pending", j, pop_data[j]));
    expected = exp_q[src][j].pop_front();
    lat = cycle - cyc_q[src][j].pop_front();
    assert (pop_data[j] == expected)
      else fail_run($sformatf("mismatch %s data: expected %h actual %h", name, expected,
                              pop_data[j]));
    if (tests[cur_row].check_latency) begin
      assert (lat == 2)
        else fail_run($sformatf("mismatch %s latency: expected 2 actual %0d", name, lat));
    end
    if (tests[cur_row].check_rr) begin
      assert (src == rr_next[j])
        else fail_run($sformatf("mismatch %s rr source: expected %0d actual %0d", name,
                                rr_next[j], src));
      rr_next[j] = (src + 1) % NP;
    end
    delivered++;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      assert (UUT.flow_xbar_checks.fail_count == 0)
        else fail_run("a bound handshake assertion failed");
      for (int j = 0; j < NQ; j++) begin
        if (pop_valid[j] && pop_ready[j]) check_pop(j);
      end
    end
  end

  // Watchdog sized from the table
  initial begin
    repeat (total_items() * NP * 10 + 200) @(posedge clk);
    fail_run("timeout, traffic did not drain in time");
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(18435));
    rst = 1'b1;
    push_valid = '0;
    push_flit = '0;
    pop_ready = '1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_row = t;
      if (tests[t].load_before_reset) park_items();
      apply_reset();
      delivered = 0;
      for (int s = 0; s < NP; s++) accepted[s] = 0;
      for (int j = 0; j < NQ; j++) rr_next[j] = 0;
      @(posedge clk);
      #2;
      for (int s = 0; s < NP; s++) begin
        fork
          automatic int src = s;
          drive_source(src);
        join_none
      end
      drive_ready();
      wait fork;
      wait (delivered == row_total());
      // Idle cycles expose duplicates or stale items
      repeat (4) @(negedge clk);
      $display("test %s done, %0d items", tests[t].name, delivered);
    end
    if (UUT.flow_xbar_checks.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== xbar/flow_demux.sv ====
// Purely combinational, and a dest beyond the last pop port leaves the flit stuck
`default_nettype none

`include "flow_xbar_cfg.svh"

module flow_demux (
  input  logic                              push_valid,
  output logic                              push_ready,
  input  flow_xbar_pkg::push_flit_t         push_flit,

  output logic [`FLOW_XBAR_NUM_POP-1:0]     lane_valid,
  input  logic [`FLOW_XBAR_NUM_POP-1:0]     lane_ready,
  output flow_xbar_pkg::payload_t           lane_data
);

  import flow_xbar_pkg::*;

  // --------------------
  // Lane select
  // --------------------

  // One-hot decode of dest gated by push_valid
  always_comb begin
    for (int j = 0; j < `FLOW_XBAR_NUM_POP; j++) begin
      lane_valid[j] = push_valid && (push_flit.dest == dest_id_t'(j));
    end
  end

  // Backpressure comes from the chosen lane only
  assign push_ready = lane_ready[push_flit.dest];

  // --------------------
  // Payload
  // --------------------

  // Broadcast to every lane, lane_valid decides who takes it
  assign lane_data = push_flit.data;

endmodule

`default_nettype wire

// ==== xbar/flow_mux_core.sv ====
// Relies on an external arbiter whose can_grant is one-hot and a subset of request
`default_nettype none

`include "flow_xbar_cfg.svh"

module flow_mux_core (
  input  flow_xbar_pkg::push_mask_t                          lane_valid,
  output flow_xbar_pkg::push_mask_t                          lane_ready,
  input  flow_xbar_pkg::payload_t [`FLOW_XBAR_NUM_PUSH-1:0] lane_data,

  output logic                                               pop_valid,
  input  logic                                               pop_ready,
  output flow_xbar_pkg::payload_t                            pop_data,

  // Arbiter side
  output flow_xbar_pkg::push_mask_t                          request,
  input  flow_xbar_pkg::push_mask_t                          can_grant,
  input  flow_xbar_pkg::push_mask_t                          grant,
  output logic                                               enable_priority_update
);

  // --------------------
  // Request path
  // --------------------

  // Every lane holding an item competes
  assign request   = lane_valid;
  assign pop_valid = |lane_valid;

  // --------------------
  // Data select
  // --------------------

  // AND-OR mux on the one-hot can_grant
  always_comb begin
    pop_data = '0;
    for (int i = 0; i < `FLOW_XBAR_NUM_PUSH; i++) begin
      if (can_grant[i]) begin
        pop_data = pop_data | lane_data[i];
      end
    end
  end

  // --------------------
  // Consumption
  // --------------------

  // Priority moves only when the downstream stage takes the item
  assign enable_priority_update = pop_ready;

  // grant already includes pop_ready, so at most one lane is released
  assign lane_ready = grant;

endmodule

`default_nettype wire

// ==== xbar/flow_xbar_core.sv ====
// Both register stages are always present, so the uncontended latency is two cycles
`default_nettype none

`include "flow_xbar_cfg.svh"

module flow_xbar_core (
  input  logic                                               clk,
  input  logic                                               rst,

  input  logic [`FLOW_XBAR_NUM_PUSH-1:0]                     push_valid,
  output logic [`FLOW_XBAR_NUM_PUSH-1:0]                     push_ready,
  input  flow_xbar_pkg::push_flit_t [`FLOW_XBAR_NUM_PUSH-1:0] push_flit,

  output logic [`FLOW_XBAR_NUM_POP-1:0]                      pop_valid,
  input  logic [`FLOW_XBAR_NUM_POP-1:0]                      pop_ready,
  output flow_xbar_pkg::payload_t [`FLOW_XBAR_NUM_POP-1:0]   pop_data,

  // Per pop port arbiter interface
  output flow_xbar_pkg::push_mask_t [`FLOW_XBAR_NUM_POP-1:0] request,
  input  flow_xbar_pkg::push_mask_t [`FLOW_XBAR_NUM_POP-1:0] can_grant,
  input  flow_xbar_pkg::push_mask_t [`FLOW_XBAR_NUM_POP-1:0] grant,
  output logic [`FLOW_XBAR_NUM_POP-1:0]                      enable_priority_update
);

  import flow_xbar_pkg::*;

  localparam int NP = `FLOW_XBAR_NUM_PUSH;
  localparam int NQ = `FLOW_XBAR_NUM_POP;

  // Demux side, indexed [source][destination]
  logic [NP-1:0][NQ-1:0] demux_valid;
  logic [NP-1:0][NQ-1:0] demux_ready;
  payload_t [NP-1:0]     demux_data;

  // Mux side, indexed [destination][source]
  push_mask_t [NQ-1:0]         mux_in_valid;
  push_mask_t [NQ-1:0]         mux_in_ready;
  payload_t [NQ-1:0][NP-1:0]   mux_in_data;

  logic [NQ-1:0]     mux_out_valid;
  logic [NQ-1:0]     mux_out_ready;
  payload_t [NQ-1:0] mux_out_data;

  // --------------------
  // Demux and lanes
  // --------------------
  for (genvar i = 0; i < NP; i++) begin : gen_push
    flow_demux flow_demux_push (
      .push_valid (push_valid[i]),
      .push_ready (push_ready[i]),
      .push_flit  (push_flit[i]),
      .lane_valid (demux_valid[i]),
      .lane_ready (demux_ready[i]),
      .lane_data  (demux_data[i])
    );

    // Transpose happens here, source-major in and destination-major out
    for (genvar j = 0; j < NQ; j++) begin : gen_lane
      flow_reg_fwd flow_reg_fwd_lane (
        .clk,
        .rst,
        .push_valid (demux_valid[i][j]),
        .push_ready (demux_ready[i][j]),
        .push_data  (demux_data[i]),
        .pop_valid  (mux_in_valid[j][i]),
        .pop_ready  (mux_in_ready[j][i]),
        .pop_data   (mux_in_data[j][i])
      );
    end
  end

  // --------------------
  // Mux and pop stage
  // --------------------
  for (genvar j = 0; j < NQ; j++) begin : gen_pop
    flow_mux_core flow_mux_core_pop (
      .lane_valid             (mux_in_valid[j]),
      .lane_ready             (mux_in_ready[j]),
      .lane_data              (mux_in_data[j]),
      .pop_valid              (mux_out_valid[j]),
      .pop_ready              (mux_out_ready[j]),
      .pop_data               (mux_out_data[j]),
      .request                (request[j]),
      .can_grant              (can_grant[j]),
      .grant                  (grant[j]),
      .enable_priority_update (enable_priority_update[j])
    );

    flow_reg_fwd flow_reg_fwd_pop (
      .clk,
      .rst,
      .push_valid (mux_out_valid[j]),
      .push_ready (mux_out_ready[j]),
      .push_data  (mux_out_data[j]),
      .pop_valid  (pop_valid[j]),
      .pop_ready  (pop_ready[j]),
      .pop_data   (pop_data[j])
    );
  end

endmodule

`default_nettype wire

// ==== xbar/flow_xbar_top.sv ====
// NUM_PUSH and NUM_POP must equal the cfg macros, which set the internal types
`default_nettype none

`include "flow_xbar_cfg.svh"

module flow_xbar_top #(
  parameter int NUM_PUSH = `FLOW_XBAR_NUM_PUSH,
  parameter int NUM_POP  = `FLOW_XBAR_NUM_POP
) (
  input  logic                                    clk,
  input  logic                                    rst,

  input  logic [NUM_PUSH-1:0]                     push_valid,
  output logic [NUM_PUSH-1:0]                     push_ready,
  input  flow_xbar_pkg::push_flit_t [NUM_PUSH-1:0] push_flit,

  output logic [NUM_POP-1:0]                      pop_valid,
  input  logic [NUM_POP-1:0]                      pop_ready,
  output flow_xbar_pkg::payload_t [NUM_POP-1:0]   pop_data
);

  import flow_xbar_pkg::*;

  push_mask_t [NUM_POP-1:0] request;
  push_mask_t [NUM_POP-1:0] can_grant;
  push_mask_t [NUM_POP-1:0] grant;
  logic [NUM_POP-1:0]       enable_priority_update;

  // Catch a size override that the types cannot follow
  if (NUM_PUSH != `FLOW_XBAR_NUM_PUSH || NUM_POP != `FLOW_XBAR_NUM_POP) begin : gen_size_check
    $error("flow_xbar_top sizes differ from flow_xbar_cfg.svh");
  end

  // --------------------
  // Crossbar datapath
  // --------------------
  flow_xbar_core flow_xbar_core_inst (
    .clk,
    .rst,
    .push_valid,
    .push_ready,
    .push_flit,
    .pop_valid,
    .pop_ready,
    .pop_data,
    .request,
    .can_grant,
    .grant,
    .enable_priority_update
  );

  // --------------------
  // Arbiters
  // --------------------

  // One round-robin arbiter per destination
  for (genvar j = 0; j < NUM_POP; j++) begin : gen_arb
    rr_arbiter rr_arbiter_pop (
      .clk,
      .rst,
      .request                (request[j]),
      .enable_priority_update (enable_priority_update[j]),
      .can_grant              (can_grant[j]),
      .grant                  (grant[j])
    );
  end

endmodule

`default_nettype wire
